//--- verilog.f
+incdir+include
logic/qspi_pkg.sv
logic/qspi_txn_if.sv
logic/axil_qspi_bridge.sv
logic/qspi_controller.sv
logic/qspi_subsystem_top.sv
dv/qspi_mem_model.sv
dv/qspi_checker.sv
dv/tb_qspi_subsystem.sv

//--- Makefile
SHELL      := /bin/bash
VERILATOR  ?= verilator
TOP        ?= tb_qspi_subsystem
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FILELIST   ?= verilog.f
VFLAGS     ?= --binary --timing --assert -j 0
FAIL_MSG   ?= TEST FAILED
PASS_MSG   ?= TEST PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_qspi_subsystem.sv
//////////////////////////////////////////////////
// Directed testbench for the AXI4-Lite QSPI subsystem
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qspi_params.svh"

module tb_qspi_subsystem;

   localparam int CLK_PERIOD = 100;
   localparam int N_ACCESSES = 24;
   localparam logic [31:0] RAM_A_BASE = 32'h0100_0000;
   localparam logic [31:0] RAM_B_BASE = 32'h0180_0000;

   logic                        clk = 1'b0;
   logic                        rstn = 1'b0;
   logic [`QSPI_AXI_ADDR_W-1:0] awaddr = '0;
   logic                        awvalid = 1'b0;
   logic                        awready;
   logic [`QSPI_AXI_DATA_W-1:0] wdata = '0;
   logic [3:0]                  wstrb = 4'h0;
   logic                        wvalid = 1'b0;
   logic                        wready;
   qspi_pkg::axi_resp_t         bresp;
   logic                        bvalid;
   logic                        bready = 1'b0;
   logic [`QSPI_AXI_ADDR_W-1:0] araddr = '0;
   logic                        arvalid = 1'b0;
   logic                        arready;
   logic [`QSPI_AXI_DATA_W-1:0] rdata;
   qspi_pkg::axi_resp_t         rresp;
   logic                        rvalid;
   logic                        rready = 1'b0;
   logic [3:0]                  spi_data_in;
   logic [3:0]                  spi_data_out;
   logic [3:0]                  spi_oe;
   logic                        spi_clk;
   logic                        spi_flash_sel;
   logic                        spi_ram_a_sel;
   logic                        spi_ram_b_sel;
   integer                      seed = 83;
   int                          flash_sel_count = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   qspi_subsystem_top i_qspi_subsystem_top (.*);

   qspi_mem_model i_qspi_mem_model (.*);

   // Number of times the flash has been selected
   always @(negedge spi_flash_sel) begin
      flash_sel_count = flash_sel_count + 1;
   end

   task automatic end_in_failure();
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   // Runaway guard sized from the access count
   initial begin
      #(N_ACCESSES * 200 * CLK_PERIOD);
      $display("Timeout: the DUT stopped answering AXI accesses");
      end_in_failure();
   end

   task automatic check_byte(input string test, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected %02h, actual %02h", test, exp, act);
         end_in_failure();
      end
   endtask

   task automatic check_resp(input string test, input qspi_pkg::axi_resp_t exp,
                             input qspi_pkg::axi_resp_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected %s, actual %s", test, exp.name(), act.name());
         end_in_failure();
      end
   endtask

   // Pins as {flash_sel, ram_a_sel, ram_b_sel, spi_clk, spi_oe}
   task automatic check_pins(input string test, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s: expected pins %08b, actual %08b", test, exp, act);
         end_in_failure();
      end
   endtask

   task automatic axi_write(input logic [31:0] addr, input logic [7:0] data,
                            output qspi_pkg::axi_resp_t resp);
      logic aw_pending;
      logic w_pending;
      aw_pending = 1'b1;
      w_pending  = 1'b1;
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= {24'h0, data};
      wstrb   <= 4'h1;
      wvalid  <= 1'b1;
      bready  <= 1'b1;
      while (aw_pending || w_pending) begin
         @(posedge clk);
         if (aw_pending && awready) begin
            awvalid    <= 1'b0;
            aw_pending = 1'b0;
         end
         if (w_pending && wready) begin
            wvalid    <= 1'b0;
            w_pending = 1'b0;
         end
      end
      do @(posedge clk); while (!bvalid);
      resp = bresp;
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [31:0] addr, input int hold,
                           output logic [7:0] data, output qspi_pkg::axi_resp_t resp);
      logic [31:0] first_word;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b0;
      do @(posedge clk); while (!arready);
      arvalid <= 1'b0;
      do @(posedge clk); while (!rvalid);
      first_word = rdata;
      data       = rdata[7:0];
      resp       = rresp;
      // Byte is zero extended into the read word
      if (first_word[31:8] !== 24'h0) begin
         $display("[ERROR] read_zero_extend: expected upper bytes 000000, actual %06h",
                  first_word[31:8]);
         end_in_failure();
      end
      repeat (hold) begin
         @(posedge clk);
         if (!rvalid || rdata !== first_word) begin
            $display("Read response changed while rready was held low");
            end_in_failure();
         end
      end
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic test_reset_state();
      check_pins("reset_state", 8'b1111_0000,
                 {spi_flash_sel, spi_ram_a_sel, spi_ram_b_sel, spi_clk, spi_oe});
   endtask

   task automatic test_flash_reads();
      logic [31:0]         addrs [4];
      logic [7:0]          data;
      qspi_pkg::axi_resp_t resp;
      addrs = '{32'h0000_0000, 32'h0000_0123, 32'h0000_0A5F, 32'h0000_0FFE};
      foreach (addrs[i]) begin
         axi_read(addrs[i], 0, data, resp);
         check_resp("flash_reads", qspi_pkg::OKAY, resp);
         check_byte("flash_reads", addrs[i][7:0] ^ 8'hA5, data);
      end
   endtask

   task automatic test_ram_banks();
      logic [31:0]         offs [2];
      logic [7:0]          da [2];
      logic [7:0]          db [2];
      logic [7:0]          data;
      qspi_pkg::axi_resp_t resp;
      offs = '{32'h010, 32'h2A7};
      foreach (offs[i]) begin
         da[i] = 8'($random(seed));
         db[i] = 8'($random(seed));
         axi_write(RAM_A_BASE | offs[i], da[i], resp);
         check_resp("ram_banks", qspi_pkg::OKAY, resp);
         axi_write(RAM_B_BASE | offs[i], db[i], resp);
         check_resp("ram_banks", qspi_pkg::OKAY, resp);
      end
      foreach (offs[i]) begin
         axi_read(RAM_A_BASE | offs[i], 0, data, resp);
         check_byte("ram_banks", da[i], data);
         axi_read(RAM_B_BASE | offs[i], 0, data, resp);
         check_byte("ram_banks", db[i], data);
      end
   endtask

   task automatic test_flash_write_refused();
      logic [7:0]          data;
      qspi_pkg::axi_resp_t resp;
      int                  sel_before;
      sel_before = flash_sel_count;
      axi_write(32'h0000_0040, 8'h3C, resp);
      check_resp("flash_write_refused", qspi_pkg::SLVERR, resp);
      if (flash_sel_count != sel_before) begin
         $display("The refused flash write still selected the flash");
         end_in_failure();
      end
      axi_read(32'h0000_0040, 0, data, resp);
      check_resp("flash_write_refused", qspi_pkg::OKAY, resp);
      check_byte("flash_write_refused", 8'h40 ^ 8'hA5, data);
   endtask

   // Consecutive writes to one RAM exercise the reselect guard
   task automatic test_back_to_back();
      logic [7:0]          vals [4];
      logic [7:0]          data;
      qspi_pkg::axi_resp_t resp;
      foreach (vals[i]) begin
         vals[i] = 8'($random(seed));
         axi_write(RAM_B_BASE | (32'h100 + i), vals[i], resp);
         check_resp("back_to_back", qspi_pkg::OKAY, resp);
      end
      foreach (vals[i]) begin
         axi_read(RAM_B_BASE | (32'h100 + i), 0, data, resp);
         check_byte("back_to_back", vals[i], data);
      end
   endtask

   task automatic test_read_backpressure();
      logic [7:0]          val;
      logic [7:0]          data;
      qspi_pkg::axi_resp_t resp;
      val = 8'($random(seed));
      axi_write(RAM_A_BASE | 32'h055, val, resp);
      axi_read(RAM_A_BASE | 32'h055, 6, data, resp);
      check_resp("read_backpressure", qspi_pkg::OKAY, resp);
      check_byte("read_backpressure", val, data);
   endtask

   initial begin
      repeat (2) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      test_reset_state();
      test_flash_reads();
      test_ram_banks();
      test_flash_write_refused();
      test_back_to_back();
      test_read_backpressure();
      $display("TEST PASSED");
      $finish;
   end

endmodule

//--- dv/qspi_checker.sv
//////////////////////////////////////////////////
// SPI select and AXI response assertions
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qspi_params.svh"

module qspi_checker (
   input logic                        clk,
   input logic                        rstn,
   input logic                        spi_flash_sel,
   input logic                        spi_ram_a_sel,
   input logic                        spi_ram_b_sel,
   input logic [3:0]                  spi_oe,
   input logic                        rvalid,
   input logic                        rready,
   input logic [`QSPI_AXI_DATA_W-1:0] rdata,
   input logic                        bvalid,
   input logic                        bready
);

   a_one_select: assert property (@(posedge clk) disable iff (!rstn)
      $countones({!spi_flash_sel, !spi_ram_a_sel, !spi_ram_b_sel}) <= 1)
      else $error("more than one SPI select is low");

   a_oe_selected: assert property (@(posedge clk) disable iff (!rstn)
      (spi_oe != 4'b0000) |-> !(spi_flash_sel && spi_ram_a_sel && spi_ram_b_sel))
      else $error("spi_oe driven with no device selected");

   a_rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
      (rvalid && !rready) |=> (rvalid && $stable(rdata)))
      else $error("rvalid or rdata changed before rready");

   a_bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
      (bvalid && !bready) |=> bvalid)
      else $error("bvalid dropped before bready");

endmodule

bind qspi_subsystem_top qspi_checker i_qspi_checker (.*);

//--- dv/qspi_mem_model.sv
//////////////////////////////////////////////////
// Behavioral QSPI flash and two quad RAMs
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qspi_params.svh"

module qspi_mem_model (
   input  logic       rstn,
   input  logic       spi_clk,
   input  logic [3:0] spi_data_out,
   input  logic [3:0] spi_oe,
   input  logic       spi_flash_sel,
   input  logic       spi_ram_a_sel,
   input  logic       spi_ram_b_sel,
   output logic [3:0] spi_data_in
);

   // Rising SPI clock edges that end each phase
   localparam int CMD_END   = 8;
   localparam int ADDR_END  = 14;
   localparam int WDATA_END = 16;
   localparam int RDATA_HI  = 20;
   localparam int RDATA_LO  = 21;

   logic [7:0]  flash_mem [0:4095];
   logic [7:0]  ram_a [0:1023];
   logic [7:0]  ram_b [0:1023];
   logic [7:0]  cmd;
   logic [23:0] addr;
   logic [7:0]  wbyte;
   logic [7:0]  rbyte;
   logic [3:0]  nib_out = 4'h0;
   int          edge_cnt = 0;
   logic        deselected;
   logic [3:0]  pins;

   assign deselected  = spi_flash_sel & spi_ram_a_sel & spi_ram_b_sel;
   assign spi_data_in = nib_out;

   // Wires the controller leaves undriven read as unknown
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         pins[i] = spi_oe[i] ? spi_data_out[i] : 1'bx;
      end
   end

   initial begin
      for (int i = 0; i < 4096; i++) begin
         flash_mem[i] = 8'(i) ^ 8'hA5;
      end
   end

   // Command and address sampled on the rising SPI clock
   always @(posedge spi_clk or posedge deselected) begin
      if (deselected) begin
         edge_cnt = 0;
      end else begin
         edge_cnt = edge_cnt + 1;
         if (edge_cnt <= CMD_END) begin
            cmd = {cmd[6:0], pins[0]};
         end else if (edge_cnt <= ADDR_END) begin
            addr = {addr[19:0], pins};
         end
         if (edge_cnt == ADDR_END) begin
            if (!spi_flash_sel) rbyte = flash_mem[addr[11:0]];
            else if (!spi_ram_a_sel) rbyte = ram_a[addr[9:0]];
            else rbyte = ram_b[addr[9:0]];
         end
         if (cmd == `QSPI_CMD_WRITE && edge_cnt > ADDR_END && edge_cnt <= WDATA_END) begin
            wbyte = {wbyte[3:0], pins};
            if (edge_cnt == WDATA_END && !spi_ram_a_sel) ram_a[addr[9:0]] = wbyte;
            if (edge_cnt == WDATA_END && !spi_ram_b_sel) ram_b[addr[9:0]] = wbyte;
         end
      end
   end

   // Read nibbles change on the falling SPI clock, zero in reset
   always @(negedge spi_clk or negedge rstn) begin
      if (!rstn) begin
         nib_out <= 4'h0;
      end else if (edge_cnt == RDATA_HI) begin
         nib_out <= rbyte[7:4];
      end else if (edge_cnt == RDATA_LO) begin
         nib_out <= rbyte[3:0];
      end
   end

endmodule

//--- logic/qspi_subsystem_top.sv
//////////////////////////////////////////////////
// AXI4-Lite to QSPI PMOD subsystem
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qspi_params.svh"

module qspi_subsystem_top (
   input  logic                        clk,
   input  logic                        rstn,
   input  logic [`QSPI_AXI_ADDR_W-1:0] awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [`QSPI_AXI_DATA_W-1:0] wdata,
   input  logic [3:0]                  wstrb,
   input  logic                        wvalid,
   output logic                        wready,
   output qspi_pkg::axi_resp_t         bresp,
   output logic                        bvalid,
   input  logic                        bready,
   input  logic [`QSPI_AXI_ADDR_W-1:0] araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [`QSPI_AXI_DATA_W-1:0] rdata,
   output qspi_pkg::axi_resp_t         rresp,
   output logic                        rvalid,
   input  logic                        rready,
   input  logic [3:0]                  spi_data_in,
   output logic [3:0]                  spi_data_out,
   output logic [3:0]                  spi_oe,
   output logic                        spi_clk,
   output logic                        spi_flash_sel,
   output logic                        spi_ram_a_sel,
   output logic                        spi_ram_b_sel
);

   qspi_txn_if i_txn_if ();

   axil_qspi_bridge i_axil_qspi_bridge (.*, .txn (i_txn_if.bridge));

   qspi_controller i_qspi_controller (.*, .txn (i_txn_if.ctrl));

endmodule

//--- logic/qspi_controller.sv
//////////////////////////////////////////////////
// QSPI sequencer for flash and two quad RAMs
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qspi_params.svh"

module qspi_controller (
   input  logic       clk,
   input  logic       rstn,
   qspi_txn_if.ctrl   txn,
   input  logic [3:0] spi_data_in,
   output logic [3:0] spi_data_out,
   output logic [3:0] spi_oe,
   output logic       spi_clk,
   output logic       spi_flash_sel,
   output logic       spi_ram_a_sel,
   output logic       spi_ram_b_sel
);

   localparam int unsigned AW = `QSPI_DEV_ADDR_W;
   localparam int unsigned DW = `QSPI_DATA_W;

   // Last count of each phase, command counts bits, the rest nibbles
   localparam logic [2:0] CMD_LAST    = 3'd7;
   localparam logic [2:0] ADDR_LAST   = 3'(AW / 4 - 1);
   localparam logic [2:0] DUMMY1_LAST = 3'd1;
   localparam logic [2:0] DUMMY2_LAST = 3'd3;
   localparam logic [2:0] DATA_LAST   = 3'(DW / 4 - 1);

   typedef enum logic [2:0] {
      ST_IDLE, ST_CMD, ST_ADDR, ST_DUMMY1, ST_DUMMY2, ST_DATA
   } state_t;

   state_t        state;
   logic          is_writing;
   logic [AW-1:0] addr_sr;
   logic [DW-1:0] data_sr;
   logic [2:0]    nibbles;
   logic [2:0]    delay_cfg;
   logic [2:0]    read_count;
   logic [7:0]    cmd;
   logic          stop_defer;
   logic          stop_held;
   logic          stop_now;
   logic          last_ram_a_sel;
   logic          last_ram_b_sel;
   logic          ram_a_block;
   logic          ram_b_block;
   logic          start_any;
   logic          accept;
   logic          nibble_step;

   assign txn.rdata = data_sr;
   assign txn.busy  = state != ST_IDLE;

   // Write stop during the low clock half waits for the rising edge
   assign stop_defer = txn.stop && is_writing && !spi_clk;
   assign stop_now   = stop_held || (txn.stop && !stop_defer);

   assign start_any   = txn.start_read || txn.start_write;
   assign ram_a_block = !last_ram_a_sel && (txn.addr.ram.bank == qspi_pkg::BANK_RAM_A);
   assign ram_b_block = !last_ram_b_sel && (txn.addr.ram.bank == qspi_pkg::BANK_RAM_B);
   assign accept      = start_any && !ram_a_block && !ram_b_block;

   // Read data is paced by the delay counter, everything else by the SPI clock
   assign nibble_step = (state == ST_DATA && !is_writing) ? (read_count == 3'd0) : spi_clk;

   // Sampled from the pins while held in reset
   always_ff @(posedge clk) begin
      if (!rstn) begin
         delay_cfg <= spi_data_in[2:0];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         stop_held <= 1'b0;
      end else begin
         stop_held <= stop_defer;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn || stop_now) begin
         state          <= ST_IDLE;
         is_writing     <= 1'b0;
         nibbles        <= 3'd0;
         txn.data_ready <= 1'b0;
         txn.data_req   <= 1'b0;
         spi_clk        <= 1'b1;
         spi_oe         <= 4'b0000;
         spi_flash_sel  <= 1'b1;
         spi_ram_a_sel  <= 1'b1;
         spi_ram_b_sel  <= 1'b1;
      end else begin
         txn.data_ready <= 1'b0;
         txn.data_req   <= 1'b0;
         if (state == ST_IDLE) begin
            if (accept) begin
               state         <= ST_CMD;
               is_writing    <= !txn.start_read && txn.addr.flash.is_ram;
               nibbles       <= CMD_LAST;
               spi_oe        <= 4'b0001;
               spi_clk       <= 1'b0;
               spi_flash_sel <= txn.addr.flash.is_ram;
               spi_ram_a_sel <= txn.addr.ram.bank != qspi_pkg::BANK_RAM_A;
               spi_ram_b_sel <= txn.addr.ram.bank != qspi_pkg::BANK_RAM_B;
            end
         end else begin
            spi_clk <= !spi_clk;
            if (nibble_step) begin
               if (nibbles == 3'd0) begin
                  case (state)
                     ST_CMD: begin
                        state   <= ST_ADDR;
                        nibbles <= ADDR_LAST;
                        spi_oe  <= 4'b1111;
                     end
                     ST_ADDR: begin
                        // RAM writes skip the dummy cycles
                        state   <= is_writing ? ST_DATA : ST_DUMMY1;
                        nibbles <= is_writing ? DATA_LAST : DUMMY1_LAST;
                     end
                     ST_DUMMY1: begin
                        state   <= ST_DUMMY2;
                        nibbles <= DUMMY2_LAST;
                        spi_oe  <= 4'b0000;
                     end
                     ST_DUMMY2: begin
                        state   <= ST_DATA;
                        nibbles <= DATA_LAST;
                     end
                     ST_DATA: begin
                        txn.data_ready <= !is_writing;
                        nibbles        <= DATA_LAST;
                     end
                     default: state <= ST_IDLE;
                  endcase
               end else begin
                  nibbles <= nibbles - 3'd1;
               end
            end else begin
               txn.data_req <= is_writing && (state == ST_DATA) && (nibbles == 3'd0);
            end
         end
      end
   end

   // Toggles between 0 and 1 once the configured delay has run out
   always_ff @(posedge clk) begin
      if (!rstn) begin
         read_count <= 3'd0;
      end else if (state != ST_IDLE) begin
         if (state == ST_DUMMY2 && spi_clk && nibbles == 3'd0) begin
            read_count <= delay_cfg;
         end else if (read_count == 3'd0) begin
            read_count <= 3'd1;
         end else begin
            read_count <= read_count - 3'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && start_any) begin
         addr_sr <= txn.addr.flash.offset;
      end else if (state == ST_ADDR && spi_clk) begin
         addr_sr <= {addr_sr[AW-5:0], 4'b0000};
      end
   end

   always_ff @(posedge clk) begin
      if (is_writing) begin
         if (spi_clk) begin
            if (nibbles == 3'd0) begin
               data_sr <= txn.wdata;
            end else if (state == ST_DATA) begin
               data_sr <= {data_sr[DW-5:0], 4'b0000};
            end
         end
      end else if (state == ST_DATA && read_count == 3'd0) begin
         data_sr <= {data_sr[DW-5:0], spi_data_in};
      end
   end

   assign cmd = is_writing ? `QSPI_CMD_WRITE : `QSPI_CMD_READ;

   always_comb begin
      case (state)
         ST_CMD:  spi_data_out = {3'b000, cmd[nibbles]};
         ST_ADDR: spi_data_out = addr_sr[AW-1 -: 4];
         ST_DATA: spi_data_out = data_sr[DW-1 -: 4];
         default: spi_data_out = 4'b1111;
      endcase
   end

   // Two cycles must pass before the same RAM is selected again
   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_ram_a_sel <= 1'b1;
         last_ram_b_sel <= 1'b1;
      end else begin
         last_ram_a_sel <= spi_ram_a_sel;
         last_ram_b_sel <= spi_ram_b_sel;
      end
   end

endmodule

//--- logic/axil_qspi_bridge.sv
//////////////////////////////////////////////////
// AXI4-Lite slave turning byte accesses into QSPI
// transactions, one access in flight
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qspi_params.svh"

module axil_qspi_bridge (
   input  logic                        clk,
   input  logic                        rstn,
   input  logic [`QSPI_AXI_ADDR_W-1:0] awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [`QSPI_AXI_DATA_W-1:0] wdata,
   input  logic [3:0]                  wstrb,
   input  logic                        wvalid,
   output logic                        wready,
   output qspi_pkg::axi_resp_t         bresp,
   output logic                        bvalid,
   input  logic                        bready,
   input  logic [`QSPI_AXI_ADDR_W-1:0] araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [`QSPI_AXI_DATA_W-1:0] rdata,
   output qspi_pkg::axi_resp_t         rresp,
   output logic                        rvalid,
   input  logic                        rready,
   qspi_txn_if.bridge                  txn
);

   localparam int unsigned MW = `QSPI_MEM_ADDR_W;
   localparam int unsigned DW = `QSPI_DATA_W;

   typedef enum logic [2:0] {S_IDLE, S_START, S_ISSUED, S_WAIT, S_BRESP, S_RRESP} state_t;

   state_t          state;
   logic            aw_done;
   logic            w_done;
   logic            is_read;
   logic            wbyte_en;
   logic [DW-1:0]   rbyte;

   // Byte lane 0 only, zero extended
   assign rdata = {{(`QSPI_AXI_DATA_W-DW){1'b0}}, rbyte};
   assign rresp = qspi_pkg::OKAY;

   // Finish as soon as the controller hands over or takes the byte
   assign txn.stop = (state == S_WAIT) && (txn.data_ready || txn.data_req);

   always_ff @(posedge clk) begin
      if (arvalid && arready) begin
         txn.addr <= araddr[MW-1:0];
      end else if (awvalid && awready) begin
         txn.addr <= awaddr[MW-1:0];
      end
      if (wvalid && wready) begin
         txn.wdata <= wdata[DW-1:0];
         wbyte_en  <= wstrb[0];
      end
      if (state == S_WAIT && txn.data_ready) begin
         rbyte <= txn.rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state           <= S_IDLE;
         aw_done         <= 1'b0;
         w_done          <= 1'b0;
         is_read         <= 1'b0;
         awready         <= 1'b0;
         wready          <= 1'b0;
         arready         <= 1'b0;
         bvalid          <= 1'b0;
         bresp           <= qspi_pkg::OKAY;
         rvalid          <= 1'b0;
         txn.start_read  <= 1'b0;
         txn.start_write <= 1'b0;
      end else begin
         awready         <= 1'b0;
         wready          <= 1'b0;
         arready         <= 1'b0;
         txn.start_read  <= 1'b0;
         txn.start_write <= 1'b0;
         case (state)
            S_IDLE: begin
               if (awvalid && awready) aw_done <= 1'b1;
               if (wvalid && wready) w_done <= 1'b1;
               if (arvalid && arready) begin
                  is_read <= 1'b1;
                  state   <= S_START;
               end else if (aw_done && w_done) begin
                  aw_done <= 1'b0;
                  w_done  <= 1'b0;
                  is_read <= 1'b0;
                  if (!txn.addr.flash.is_ram) begin
                     // Flash is read only
                     bresp  <= qspi_pkg::SLVERR;
                     bvalid <= 1'b1;
                     state  <= S_BRESP;
                  end else if (!wbyte_en) begin
                     bresp  <= qspi_pkg::OKAY;
                     bvalid <= 1'b1;
                     state  <= S_BRESP;
                  end else begin
                     state <= S_START;
                  end
               end else begin
                  awready <= awvalid && !aw_done && !awready;
                  wready  <= wvalid && !w_done && !wready;
                  // Reads only when no write has begun
                  arready <= arvalid && !arready && !awvalid && !wvalid &&
                             !aw_done && !w_done && !awready && !wready;
               end
            end
            S_START: begin
               if (!txn.busy) begin
                  txn.start_read  <= is_read;
                  txn.start_write <= !is_read;
                  state           <= S_ISSUED;
               end
            end
            S_ISSUED: state <= S_WAIT;
            S_WAIT: begin
               if (txn.data_ready) begin
                  rvalid <= 1'b1;
                  state  <= S_RRESP;
               end else if (txn.data_req) begin
                  bresp  <= qspi_pkg::OKAY;
                  bvalid <= 1'b1;
                  state  <= S_BRESP;
               end else if (!txn.busy) begin
                  // Start was refused by the reselect guard, try again
                  state <= S_START;
               end
            end
            S_BRESP: begin
               if (bready) begin
                  bvalid <= 1'b0;
                  state  <= S_IDLE;
               end
            end
            S_RRESP: begin
               if (rready) begin
                  rvalid <= 1'b0;
                  state  <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

//--- logic/qspi_txn_if.sv
//////////////////////////////////////////////////
// Byte transaction link, bridge to QSPI controller
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "qspi_params.svh"

interface qspi_txn_if;

   // Request side
   qspi_pkg::mem_addr_t     addr;
   logic [`QSPI_DATA_W-1:0] wdata;
   logic                    start_read;
   logic                    start_write;
   logic                    stop;

   // Completion side
   logic [`QSPI_DATA_W-1:0] rdata;
   logic                    data_ready;
   logic                    data_req;
   logic                    busy;

   modport bridge (
      output addr, wdata, start_read, start_write, stop,
      input  rdata, data_ready, data_req, busy
   );

   modport ctrl (
      input  addr, wdata, start_read, start_write, stop,
      output rdata, data_ready, data_req, busy
   );

endinterface

//--- logic/qspi_pkg.sv
//////////////////////////////////////////////////
// Shared types for the QSPI subsystem
//////////////////////////////////////////////////
`include "qspi_params.svh"

package qspi_pkg;

   typedef enum logic [1:0] {
      BANK_FLASH_LO = 2'b00,
      BANK_FLASH_HI = 2'b01,
      BANK_RAM_A    = 2'b10,
      BANK_RAM_B    = 2'b11
   } mem_bank_t;

   typedef struct packed {
      logic                        is_ram;
      logic [`QSPI_DEV_ADDR_W-1:0] offset;
   } flash_view_t;

   typedef struct packed {
      mem_bank_t                   bank;
      logic [`QSPI_DEV_ADDR_W-2:0] offset;
   } ram_view_t;

   // Same address word, seen as flash or as RAM bank
   typedef union packed {
      flash_view_t flash;
      ram_view_t   ram;
   } mem_addr_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axi_resp_t;

endpackage

//--- include/qspi_params.svh
//////////////////////////////////////////////////
// QSPI subsystem widths and flash/RAM command codes
//////////////////////////////////////////////////
`ifndef QSPI_PARAMS_SVH
`define QSPI_PARAMS_SVH

// Internal address: RAM flag or bank bits above the device offset
`define QSPI_MEM_ADDR_W 25
`define QSPI_DEV_ADDR_W 24
`define QSPI_DATA_W     8

// AXI4-Lite side, bits above the memory address are ignored
`define QSPI_AXI_ADDR_W 32
`define QSPI_AXI_DATA_W 32

`define QSPI_CMD_READ   8'hEB
`define QSPI_CMD_WRITE  8'h38

`endif
